/* Makefile */
SIM      := verilator
TOP      := riscv_v_logic_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
FLAGS    := --binary -j 0 -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) testbench/riscv_v_logic_model.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+testbench
hw/riscv_v_pkg.sv
hw/riscv_v_logic_decode.sv
hw/riscv_v_bitwise.sv
hw/riscv_v_shifter.sv
hw/riscv_v_logic_alu.sv
hw/riscv_v_logic_unit.sv
testbench/riscv_v_logic_tb.sv

/* hw/riscv_v_bitwise.sv */
// AND, OR and XOR in element-wise, mask and reduction forms
// Result is zero unless one of the operator selectors is set

`timescale 1ns/10ps

module riscv_v_bitwise #(
    parameter int VLEN = 128
) (
    input  logic                     is_and,
    input  logic                     is_or,
    input  logic                     is_xor,
    input  logic                     is_mask,
    input  logic                     is_reduct,
    input  riscv_v_pkg::sew_onehot_t sew_onehot,
    input  logic [VLEN-1:0]          srca,
    input  logic [VLEN-1:0]          srcb,
    output logic [VLEN-1:0]          result
);
    import riscv_v_pkg::*;

    logic            is_elem;
    logic [2:0]      op_sel;
    logic [VLEN-1:0] wide_result;
    logic [VLEN-1:0] red_result;

    function automatic logic [ELEN-1:0] apply_op(
        input logic [2:0]      sel,
        input logic [ELEN-1:0] a,
        input logic [ELEN-1:0] b
    );
        return ({ELEN{sel[0]}} & (a & b)) |
               ({ELEN{sel[1]}} & (a | b)) |
               ({ELEN{sel[2]}} & (a ^ b));
    endfunction

    assign is_elem = ~is_mask & ~is_reduct;
    assign op_sel  = {is_xor, is_or, is_and};

    // No element boundaries needed for a bitwise operator
    assign wide_result = ({VLEN{is_and}} & (srca & srcb)) |
                         ({VLEN{is_or}}  & (srca | srcb)) |
                         ({VLEN{is_xor}} & (srca ^ srcb));

    // Upper bits stay zero through the halvings since both halves are zero there
    always_comb begin
        logic [ELEN-1:0] h64;
        logic [ELEN-1:0] h32;
        logic [ELEN-1:0] h16;
        logic [ELEN-1:0] h8;
        logic [ELEN-1:0] fold;
        logic [ELEN-1:0] seed;
        h64 = srcb[ELEN-1:0];
        for (int w = 1; w < VLEN/ELEN; w++) begin
            h64 = apply_op(op_sel, h64, srcb[w*ELEN +: ELEN]);
        end
        h32 = apply_op(op_sel, {32'b0, h64[63:32]}, {32'b0, h64[31:0]});
        h16 = apply_op(op_sel, {48'b0, h32[31:16]}, {48'b0, h32[15:0]});
        h8  = apply_op(op_sel, {56'b0, h16[15:8]}, {56'b0, h16[7:0]});
        fold = h64;
        seed = srca[ELEN-1:0];
        if (sew_onehot[0]) begin
            fold = h8;
            seed = {56'b0, srca[7:0]};
        end else if (sew_onehot[1]) begin
            fold = h16;
            seed = {48'b0, srca[15:0]};
        end else if (sew_onehot[2]) begin
            fold = h32;
            seed = {32'b0, srca[31:0]};
        end
        red_result = '0;
        red_result[ELEN-1:0] = apply_op(op_sel, seed, fold);
    end

    assign result = (is_elem | is_mask) ? wide_result : red_result;

endmodule : riscv_v_bitwise

/* hw/riscv_v_logic_alu.sv */
// Logical ALU of the vector unit
// Feeds the bitwise unit and the shifter, then merges their results

`timescale 1ns/10ps

module riscv_v_logic_alu #(
    parameter int VLEN = 128
) (
    input  logic                     is_and,
    input  logic                     is_or,
    input  logic                     is_xor,
    input  logic                     is_mask,
    input  logic                     is_reduct,
    input  logic                     is_shift,
    input  logic                     is_left,
    input  logic                     is_arith,
    input  riscv_v_pkg::sew_onehot_t sew_onehot,
    input  logic [VLEN-1:0]          srca,
    input  logic [VLEN-1:0]          srcb,
    output logic [VLEN-1:0]          result
);
    logic [VLEN-1:0] bitwise_result;
    logic [VLEN-1:0] shifter_result;

    riscv_v_bitwise #(
        .VLEN(VLEN)
    ) bitwise (
        .is_and(is_and),
        .is_or(is_or),
        .is_xor(is_xor),
        .is_mask(is_mask),
        .is_reduct(is_reduct),
        .sew_onehot(sew_onehot),
        .srca(srca),
        .srcb(srcb),
        .result(bitwise_result)
    );

    riscv_v_shifter #(
        .VLEN(VLEN)
    ) shifter (
        .is_shift(is_shift),
        .is_left(is_left),
        .is_arith(is_arith),
        .sew_onehot(sew_onehot),
        .srca(srca),
        .srcb(srcb),
        .result(shifter_result)
    );

    // Only one class is active, the other block drives zero
    assign result = bitwise_result | shifter_result;

endmodule : riscv_v_logic_alu

/* hw/riscv_v_logic_decode.sv */
// Decode of the vector logic operation code
// Gives one-hot class and operator selectors plus a one-hot element width

`timescale 1ns/10ps

module riscv_v_logic_decode (
    input  riscv_v_pkg::logic_op_t   op,
    input  riscv_v_pkg::sew_t        sew,
    output logic                     is_and,
    output logic                     is_or,
    output logic                     is_xor,
    output logic                     is_mask,
    output logic                     is_reduct,
    output logic                     is_shift,
    output logic                     is_left,
    output logic                     is_arith,
    output riscv_v_pkg::sew_onehot_t sew_onehot
);
    import riscv_v_pkg::*;

    always_comb begin
        is_and    = 1'b0;
        is_or     = 1'b0;
        is_xor    = 1'b0;
        is_mask   = 1'b0;
        is_reduct = 1'b0;
        is_shift  = 1'b0;
        is_left   = 1'b0;
        is_arith  = 1'b0;
        case (op)
            OP_AND:    is_and = 1'b1;
            OP_OR:     is_or  = 1'b1;
            OP_XOR:    is_xor = 1'b1;
            OP_MAND: begin
                is_and  = 1'b1;
                is_mask = 1'b1;
            end
            OP_MOR: begin
                is_or   = 1'b1;
                is_mask = 1'b1;
            end
            OP_MXOR: begin
                is_xor  = 1'b1;
                is_mask = 1'b1;
            end
            OP_REDAND: begin
                is_and    = 1'b1;
                is_reduct = 1'b1;
            end
            OP_REDOR: begin
                is_or     = 1'b1;
                is_reduct = 1'b1;
            end
            OP_REDXOR: begin
                is_xor    = 1'b1;
                is_reduct = 1'b1;
            end
            OP_SLL: begin
                is_shift = 1'b1;
                is_left  = 1'b1;
            end
            OP_SRL:    is_shift = 1'b1;
            OP_SRA: begin
                is_shift = 1'b1;
                is_arith = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (sew)
            SEW_8:   sew_onehot = 4'b0001;
            SEW_16:  sew_onehot = 4'b0010;
            SEW_32:  sew_onehot = 4'b0100;
            default: sew_onehot = 4'b1000;
        endcase
    end

endmodule : riscv_v_logic_decode

/* hw/riscv_v_logic_unit.sv */
// Top level of the vector logic execution unit
// One operation per in_valid strobe, registered result one cycle later

`timescale 1ns/10ps

module riscv_v_logic_unit #(
    parameter int VLEN = 128
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  riscv_v_pkg::logic_op_t op,
    input  riscv_v_pkg::sew_t      sew,
    input  logic [VLEN-1:0]        srca,
    input  logic [VLEN-1:0]        srcb,
    output logic                   out_valid,
    output logic [VLEN-1:0]        result
);
    import riscv_v_pkg::*;

    logic            is_and;
    logic            is_or;
    logic            is_xor;
    logic            is_mask;
    logic            is_reduct;
    logic            is_shift;
    logic            is_left;
    logic            is_arith;
    sew_onehot_t     sew_onehot;
    logic [VLEN-1:0] alu_result;

    riscv_v_logic_decode decode (
        .op(op),
        .sew(sew),
        .is_and(is_and),
        .is_or(is_or),
        .is_xor(is_xor),
        .is_mask(is_mask),
        .is_reduct(is_reduct),
        .is_shift(is_shift),
        .is_left(is_left),
        .is_arith(is_arith),
        .sew_onehot(sew_onehot)
    );

    riscv_v_logic_alu #(
        .VLEN(VLEN)
    ) alu (
        .is_and(is_and),
        .is_or(is_or),
        .is_xor(is_xor),
        .is_mask(is_mask),
        .is_reduct(is_reduct),
        .is_shift(is_shift),
        .is_left(is_left),
        .is_arith(is_arith),
        .sew_onehot(sew_onehot),
        .srca(srca),
        .srcb(srcb),
        .result(alu_result)
    );

    // Result holds between strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                result <= alu_result;
            end
        end
    end

endmodule : riscv_v_logic_unit

/* hw/riscv_v_pkg.sv */
// Shared encodings for the vector logic unit
// Operation codes, element widths and the one-hot width vector,
// imported by the RTL and the testbench alike

package riscv_v_pkg;

    // Widest element, also the lane size of the shifter
    parameter int ELEN = 64;

    // Codes 12 to 15 are undefined and give a zero result
    typedef enum logic [3:0] {
        OP_AND    = 4'd0,
        OP_OR     = 4'd1,
        OP_XOR    = 4'd2,
        OP_MAND   = 4'd3,
        OP_MOR    = 4'd4,
        OP_MXOR   = 4'd5,
        OP_REDAND = 4'd6,
        OP_REDOR  = 4'd7,
        OP_REDXOR = 4'd8,
        OP_SLL    = 4'd9,
        OP_SRL    = 4'd10,
        OP_SRA    = 4'd11
    } logic_op_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // Bit 0 is 8, bit 1 is 16, bit 2 is 32, bit 3 is 64
    typedef logic [3:0] sew_onehot_t;

endpackage : riscv_v_pkg

/* hw/riscv_v_shifter.sv */
// Element-wise shifter for SLL, SRL and SRA
// Built per 64-bit lane, each element shifted by its own amount from srcb

`timescale 1ns/10ps

module riscv_v_shifter #(
    parameter int VLEN = 128
) (
    input  logic                     is_shift,
    input  logic                     is_left,
    input  logic                     is_arith,
    input  riscv_v_pkg::sew_onehot_t sew_onehot,
    input  logic [VLEN-1:0]          srca,
    input  logic [VLEN-1:0]          srcb,
    output logic [VLEN-1:0]          result
);
    import riscv_v_pkg::*;

    for (genvar l = 0; l < VLEN/ELEN; l++) begin : g_lane
        logic [ELEN-1:0] by_sew [4];
        logic [ELEN-1:0] lane;

        for (genvar k = 0; k < 4; k++) begin : g_sew
            localparam int W = 8 << k;

            for (genvar e = 0; e < ELEN/W; e++) begin : g_elem
                logic [W-1:0]         a;
                logic [$clog2(W)-1:0] amt;
                logic signed [W:0]    ext;
                logic [W:0]           sra;

                assign a   = srca[l*ELEN + e*W +: W];
                // Only the low log2(SEW) bits count
                assign amt = srcb[l*ELEN + e*W +: $clog2(W)];
                // Extra top bit carries the fill value for right shifts
                assign ext = {is_arith & a[W-1], a};
                assign sra = ext >>> amt;
                assign by_sew[k][e*W +: W] = is_left ? (a << amt) : sra[W-1:0];
            end
        end

        assign lane = ({ELEN{sew_onehot[0]}} & by_sew[0]) |
                      ({ELEN{sew_onehot[1]}} & by_sew[1]) |
                      ({ELEN{sew_onehot[2]}} & by_sew[2]) |
                      ({ELEN{sew_onehot[3]}} & by_sew[3]);

        assign result[l*ELEN +: ELEN] = is_shift ? lane : '0;
    end

endmodule : riscv_v_shifter

/* testbench/riscv_v_logic_model.svh */
// Reference model of the vector logic unit, included inside the testbench module
// Needs VLEN and the riscv_v_pkg encodings in scope before the include

`ifndef RISCV_V_LOGIC_MODEL_SVH
`define RISCV_V_LOGIC_MODEL_SVH

// Kind 0 is AND, 1 is OR, 2 is XOR
function automatic logic [63:0] bool_op(input int kind, input logic [63:0] x,
                                        input logic [63:0] y);
    case (kind)
        0:       return x & y;
        1:       return x | y;
        default: return x ^ y;
    endcase
endfunction

// Element i of width w, zero extended
function automatic logic [63:0] elem_at(input logic [VLEN-1:0] v, input int i, input int w);
    logic [VLEN-1:0] sh;
    logic [63:0]     mask;
    sh   = v >> (i * w);
    mask = {64{1'b1}} >> (64 - w);
    return sh[63:0] & mask;
endfunction

function automatic logic [VLEN-1:0] expected_result(input logic [3:0] code,
                                                    input logic [1:0] width,
                                                    input logic [VLEN-1:0] a,
                                                    input logic [VLEN-1:0] b);
    int              w;
    int              n;
    int              kind;
    int              amt;
    logic [63:0]     mask;
    logic [63:0]     e;
    logic [63:0]     r;
    logic [63:0]     acc;
    logic [VLEN-1:0] wide;
    logic [VLEN-1:0] res;
    w    = 8 << width;
    n    = VLEN / w;
    mask = {64{1'b1}} >> (64 - w);
    res  = '0;
    case (code)
        OP_AND, OP_MAND: res = a & b;
        OP_OR, OP_MOR:   res = a | b;
        OP_XOR, OP_MXOR: res = a ^ b;
        OP_REDAND, OP_REDOR, OP_REDXOR: begin
            kind = int'(code) - int'(OP_REDAND);
            acc  = elem_at(b, 0, w);
            for (int i = 1; i < n; i++) begin
                acc = bool_op(kind, acc, elem_at(b, i, w));
            end
            res[63:0] = bool_op(kind, elem_at(a, 0, w), acc);
        end
        OP_SLL, OP_SRL, OP_SRA: begin
            for (int i = 0; i < n; i++) begin
                e   = elem_at(a, i, w);
                // Amount is the low log2(SEW) bits
                amt = int'(elem_at(b, i, w) & 64'(w - 1));
                if (code == OP_SLL) begin
                    r = (e << amt) & mask;
                end else begin
                    r = e >> amt;
                    if (code == OP_SRA && e[w-1]) begin
                        r = r | (mask & ~(mask >> amt));
                    end
                end
                wide       = '0;
                wide[63:0] = r;
                res        = res | (wide << (i * w));
            end
        end
        default: res = '0;
    endcase
    return res;
endfunction

`endif

/* testbench/riscv_v_logic_tb.sv */
// Testbench for the vector logic unit
// Applies a directed table and random entries, each checked against the model

`timescale 1ns/10ps

module riscv_v_logic_tb;
    import riscv_v_pkg::*;

    localparam int              VLEN    = 128;
    localparam int              TIMEOUT = 20;
    localparam logic [VLEN-1:0] PAT_A   = 128'hF0E1_D2C3_B4A5_9687_7869_5A4B_3C2D_1E0F;
    localparam logic [VLEN-1:0] PAT_B   = 128'h0FF0_33CC_55AA_C3C3_8001_7FFE_FFFF_0000;
    // Negative in every element for all widths
    localparam logic [VLEN-1:0] PAT_NEG = {16{8'h81}};

    typedef struct packed {
        logic [3:0]      op;
        logic [1:0]      sew;
        logic [VLEN-1:0] srca;
        logic [VLEN-1:0] srcb;
        logic [VLEN-1:0] expected;
        logic            gap;
    } entry_t;

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    logic_op_t       op;
    sew_t            sew;
    logic [VLEN-1:0] srca;
    logic [VLEN-1:0] srcb;
    logic            out_valid;
    logic [VLEN-1:0] result;
    entry_t          table_q[$];
    entry_t          ent;
    int              seed;
    int              cycles;

    `include "riscv_v_logic_model.svh"

    riscv_v_logic_unit #(
        .VLEN(VLEN)
    ) UUT (
        .clk(clk),
        .arst_n(arst_n),
        .in_valid(in_valid),
        .op(op),
        .sew(sew),
        .srca(srca),
        .srcb(srcb),
        .out_valid(out_valid),
        .result(result)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [VLEN-1:0] got,
                               input logic [VLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input int index);
        $display("Timeout: out_valid never arrived for entry %0d", index);
        $display("TESTS FAILED");
        $fatal(1, "No result from the DUT");
    endtask

    function automatic void add_entry(input logic [3:0] code, input logic [1:0] width,
                                      input logic [VLEN-1:0] a, input logic [VLEN-1:0] b,
                                      input logic gap);
        entry_t e;
        e.op       = code;
        e.sew      = width;
        e.srca     = a;
        e.srcb     = b;
        e.gap      = gap;
        e.expected = expected_result(code, width, a, b);
        table_q.push_back(e);
    endfunction

    // Amounts of zero and SEW-1, some with junk above log2(SEW)
    function automatic logic [VLEN-1:0] amount_pattern(input logic [1:0] width);
        int              w;
        logic [63:0]     mask;
        logic [63:0]     amt;
        logic [VLEN-1:0] wide;
        logic [VLEN-1:0] v;
        w    = 8 << width;
        mask = {64{1'b1}} >> (64 - w);
        v    = '0;
        for (int i = 0; i < VLEN / w; i++) begin
            case (i % 4)
                0:       amt = 64'd0;
                1:       amt = 64'(w - 1);
                2:       amt = mask & ~64'(w - 1);
                default: amt = (mask & ~64'(w - 1)) | 64'd3;
            endcase
            wide       = '0;
            wide[63:0] = amt;
            v          = v | (wide << (i * w));
        end
        return v;
    endfunction

    function automatic logic [VLEN-1:0] random_vec();
        logic [VLEN-1:0] v;
        for (int i = 0; i < VLEN / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    initial begin
        seed     = 83;
        clk      = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        op       = OP_AND;
        sew      = SEW_8;
        srca     = '0;
        srcb     = '0;

        for (int s = 0; s < 4; s++) begin
            for (int c = 0; c < 6; c++) begin
                add_entry(4'(c), 2'(s), PAT_A, PAT_B, 1'b0);
            end
            for (int c = 6; c < 9; c++) begin
                add_entry(4'(c), 2'(s), PAT_A, PAT_B, 1'b0);
                add_entry(4'(c), 2'(s), PAT_NEG, '1, c == 8);
            end
            for (int c = 9; c < 12; c++) begin
                add_entry(4'(c), 2'(s), PAT_A, amount_pattern(2'(s)), 1'b0);
                add_entry(4'(c), 2'(s), PAT_NEG, amount_pattern(2'(s)), 1'b0);
                add_entry(4'(c), 2'(s), PAT_NEG, PAT_B, 1'b1);
            end
        end
        // Undefined codes
        for (int c = 12; c < 16; c++) begin
            add_entry(4'(c), 2'(c), PAT_A, PAT_B, 1'(c % 2));
        end
        for (int i = 0; i < 200; i++) begin
            logic [3:0]      code;
            logic [1:0]      width;
            logic [VLEN-1:0] a;
            logic [VLEN-1:0] b;
            logic            gap;
            code  = 4'($random(seed));
            width = 2'($random(seed));
            a     = random_vec();
            b     = random_vec();
            gap   = (2'($random(seed)) == 2'd0);
            add_entry(code, width, a, b, gap);
        end

        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", VLEN'(out_valid), '0);
        check_value("result", result, '0);

        foreach (table_q[i]) begin
            ent      = table_q[i];
            in_valid = 1'b1;
            op       = logic_op_t'(ent.op);
            sew      = sew_t'(ent.sew);
            srca     = ent.srca;
            srcb     = ent.srcb;
            cycles   = 0;
            do begin
                @(negedge clk);
                in_valid = 1'b0;
                cycles++;
            end while (!out_valid && cycles < TIMEOUT);
            if (!out_valid) begin
                report_timeout(i);
            end
            check_value("latency", VLEN'(cycles), VLEN'(1));
            check_value("result", result, ent.expected);
            if (ent.gap) begin
                // Idle inputs change but result holds
                srca = ~ent.srca;
                srcb = ~ent.srcb;
                @(negedge clk);
                check_value("out_valid", VLEN'(out_valid), '0);
                check_value("result", result, ent.expected);
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule : riscv_v_logic_tb
